// File: filelist.f
+incdir+rtl
rtl/ring_pkg.sv
rtl/ring_inject.sv
rtl/ring_eject.sv
rtl/ring_node.sv
rtl/ring_bus_top.sv
tb/ring_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the ring bus testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module ring_bus_tb \
  -Mdir obj_dir -o ring_bus_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/ring_bus_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// File: tb/ring_bus_tb.sv
// self-checking testbench for ring_bus_top, run as the top module with the RTL from filelist.f
`timescale 1ns/1ps
`include "ring_consts.svh"

module ring_bus_tb;

  import ring_pkg::*;

  localparam int N          = `RING_NODES;
  localparam int NTAG       = 1 << `RING_TAG_W;
  // about 600 requests at up to one per cycle, plus wait and loop time, with margin
  localparam int MAX_CYCLES = 3000;
  localparam int WAIT_LIMIT = 400;
  localparam int RAND_REQS  = 30;
  localparam int SAT_REQS   = 40;

  logic                   clk;
  logic                   rst;
  logic [1:0][N-1:0]      req;
  ring_req_t              flit [2][N];
  logic [1:0][N-1:0]      ready;

  logic [N-1:0]           req_a;
  logic [N-1:0]           req_b;
  ring_req_t              req_a_flit [N];
  ring_req_t              req_b_flit [N];
  logic [N-1:0]           ready_a;
  logic [N-1:0]           ready_b;
  logic [N-1:0]           deliver_valid;
  ring_flit_t             deliver_flit [N];
  logic [N-1:0]           retire_valid;
  logic [`RING_TAG_W-1:0] retire_tag [N];

  // scoreboard, indexed by source node and tag
  ring_req_t              exp_req  [N][NTAG];
  bit                     pend_dlv [N][NTAG];
  bit                     pend_ret [N][NTAG];
  int                     rise_cyc [N][NTAG];
  int                     ret_cyc  [N][NTAG];

  // per port state, port 0 is A
  logic [`RING_TAG_W-1:0] last_tag   [2][N];
  logic [`RING_TAG_W-2:0] tag_cnt    [2][N];
  bit                     prev_ready [2][N];
  int                     wait_cnt   [2][N];
  int                     quota      [2][N];
  int                     think      [2][N];
  bit                     has_cmd    [2][N];
  ring_req_t              cmd        [2][N];

  integer seed;
  int     cycles = 0;
  int     gap_mask;
  int     raised;
  int     accepted;
  int     delivered;
  int     retired;
  int     outstanding;
  int     value_errs;
  int     other_errs;
  bit     seen_req;

  assign req_a = req[0];
  assign req_b = req[1];
  assign ready = {ready_b, ready_a};

  for (genvar i = 0; i < N; i++) begin : g_flit
    assign req_a_flit[i] = flit[0][i];
    assign req_b_flit[i] = flit[1][i];
  end

  ring_bus_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .req_a         (req_a),
    .req_b         (req_b),
    .req_a_flit    (req_a_flit),
    .req_b_flit    (req_b_flit),
    .ready_a       (ready_a),
    .ready_b       (ready_b),
    .deliver_valid (deliver_valid),
    .deliver_flit  (deliver_flit),
    .retire_valid  (retire_valid),
    .retire_tag    (retire_tag)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d requests outstanding", cycles, outstanding);
      $display("Simulation failed");
      $finish;
    end
  end

  // ============================================================
  // concurrent checks
  // ============================================================

  a_reset_state: assert property (
    @(posedge clk) rst |=> (ready_a == '1 && ready_b == '1 &&
                            deliver_valid == '0 && retire_valid == '0)
  ) else begin
    value_errs = value_errs + 1;
    $display("FAIL ready_a=%h ready_b=%h deliver_valid=%h retire_valid=%h after reset",
             ready_a, ready_b, deliver_valid, retire_valid);
  end

  for (genvar n = 0; n < N; n++) begin : g_node_chk
    a_quiet: assert property (
      @(posedge clk) disable iff (rst) !seen_req |-> !(deliver_valid[n] || retire_valid[n])
    ) else begin
      value_errs = value_errs + 1;
      $display("FAIL deliver_valid[%0d]=%h retire_valid[%0d]=%h before any request",
               n, deliver_valid[n], n, retire_valid[n]);
    end

    a_dst_match: assert property (
      @(posedge clk) disable iff (rst)
      deliver_valid[n] |-> (deliver_flit[n].used && deliver_flit[n].req.dst == `RING_ID_W'(n))
    ) else begin
      value_errs = value_errs + 1;
      $display("FAIL deliver_flit[%0d] used=%h dst=%h expected dst %h",
               n, deliver_flit[n].used, deliver_flit[n].req.dst, n);
    end
  end

  // ============================================================
  // stimulus and scoreboard
  // ============================================================

  task automatic make_req(input int p, input int n, input int d, output ring_req_t r);
    int v;
    v      = $random(seed);
    r.dst  = `RING_ID_W'(d);
    r.op   = ring_op_e'(2'($unsigned(v) % 3));
    r.addr = `RING_ADDR_W'($random(seed));
    // top tag bit names the port, so tags never clash between A and B
    r.tag  = {p[0], tag_cnt[p][n]};
    tag_cnt[p][n] = tag_cnt[p][n] + 1'b1;
  endtask

  task automatic post_cmd(input int p, input int n, input int d,
                          output logic [`RING_TAG_W-1:0] t);
    ring_req_t r;
    make_req(p, n, d, r);
    cmd[p][n]     = r;
    has_cmd[p][n] = 1'b1;
    t             = r.tag;
  endtask

  task automatic record_accept(input int p, input int n);
    ring_req_t r;
    r = flit[p][n];
    assert (!pend_ret[n][r.tag]) else begin
      other_errs++;
      $display("node %0d port %0d reused tag %h while it was outstanding", n, p, r.tag);
    end
    exp_req[n][r.tag]  = r;
    pend_dlv[n][r.tag] = 1'b1;
    pend_ret[n][r.tag] = 1'b1;
    last_tag[p][n]     = r.tag;
    accepted++;
    outstanding++;
    seen_req <= 1'b1;
  endtask

  // ready rising marks the cycle after insertion
  task automatic track_ready();
    for (int p = 0; p < 2; p++) begin
      for (int n = 0; n < N; n++) begin
        if (ready[p][n] && !prev_ready[p][n]) begin
          rise_cyc[n][last_tag[p][n]] = cycles;
        end
        if (ready[p][n]) begin
          wait_cnt[p][n] = 0;
        end else begin
          wait_cnt[p][n]++;
          assert (wait_cnt[p][n] != WAIT_LIMIT) else begin
            other_errs++;
            $display("port %0d of node %0d waited %0d cycles for ready", p, n, WAIT_LIMIT);
          end
        end
        prev_ready[p][n] = ready[p][n];
      end
    end
  endtask

  task automatic check_deliver(input int n);
    ring_flit_t f;
    int         h;
    f = deliver_flit[n];
    h = ((n - int'(f.src) + N - 1) % N) + 1;
    assert (pend_dlv[f.src][f.req.tag]) else begin
      other_errs++;
      $display("node %0d got a delivery that was not outstanding, src %0d tag %h",
               n, f.src, f.req.tag);
    end
    if (pend_dlv[f.src][f.req.tag]) begin
      assert (f.req == exp_req[f.src][f.req.tag]) else begin
        value_errs++;
        $display("FAIL deliver_flit[%0d].req got %h expected %h",
                 n, f.req, exp_req[f.src][f.req.tag]);
      end
      assert (cycles - rise_cyc[f.src][f.req.tag] == h) else begin
        other_errs++;
        $display("delivery at node %0d from node %0d took %0d cycles instead of %0d",
                 n, f.src, cycles - rise_cyc[f.src][f.req.tag], h);
      end
      pend_dlv[f.src][f.req.tag] = 1'b0;
      delivered++;
    end
  endtask

  task automatic check_retire(input int n);
    logic [`RING_TAG_W-1:0] t;
    t = retire_tag[n];
    assert (pend_ret[n][t]) else begin
      other_errs++;
      $display("node %0d retired tag %h that was not outstanding", n, t);
    end
    if (pend_ret[n][t]) begin
      assert (!pend_dlv[n][t]) else begin
        other_errs++;
        $display("node %0d retired tag %h before it was delivered", n, t);
      end
      assert (cycles - rise_cyc[n][t] == N) else begin
        other_errs++;
        $display("retire of tag %h at node %0d took %0d cycles instead of %0d",
                 t, n, cycles - rise_cyc[n][t], N);
      end
      pend_ret[n][t] = 1'b0;
      ret_cyc[n][t]  = cycles;
      retired++;
      outstanding--;
    end
  endtask

  task automatic drive_ports();
    ring_req_t r;
    for (int p = 0; p < 2; p++) begin
      for (int n = 0; n < N; n++) begin
        if (req[p][n] && ready[p][n]) begin
          record_accept(p, n);
          req[p][n] <= 1'b0;
          think[p][n] = $random(seed) & gap_mask;
        end else if (!req[p][n] && ready[p][n]) begin
          if (has_cmd[p][n]) begin
            has_cmd[p][n] = 1'b0;
            req[p][n]  <= 1'b1;
            flit[p][n] <= cmd[p][n];
            raised++;
          end else if (quota[p][n] > 0 && think[p][n] > 0) begin
            think[p][n]--;
          end else if (quota[p][n] > 0) begin
            make_req(p, n, $random(seed) & (N - 1), r);
            quota[p][n]--;
            req[p][n]  <= 1'b1;
            flit[p][n] <= r;
            raised++;
          end
        end
      end
    end
  endtask

  task automatic tick();
    @(posedge clk);
    track_ready();
    for (int n = 0; n < N; n++) begin
      if (deliver_valid[n]) check_deliver(n);
    end
    for (int n = 0; n < N; n++) begin
      if (retire_valid[n]) check_retire(n);
    end
    drive_ports();
  endtask

  function automatic bit work_left();
    bit busy;
    busy = (raised != accepted) || (outstanding != 0);
    for (int p = 0; p < 2; p++) begin
      for (int n = 0; n < N; n++) begin
        busy = busy || has_cmd[p][n] || (quota[p][n] > 0);
      end
    end
    return busy;
  endfunction

  task automatic wait_idle();
    while (work_left()) begin
      tick();
    end
  endtask

  // both ports full in the same cycle, so A must come back first
  task automatic a_before_b(input int s);
    logic [`RING_TAG_W-1:0] ta;
    logic [`RING_TAG_W-1:0] tb;
    post_cmd(0, s, (s + 1) % N, ta);
    post_cmd(1, s, (s + 2) % N, tb);
    wait_idle();
    assert (ret_cyc[s][ta] < ret_cyc[s][tb]) else begin
      other_errs++;
      $display("node %0d retired port B's request before port A's", s);
    end
  endtask

  task automatic run_traffic(input int count, input int mask);
    gap_mask = mask;
    for (int p = 0; p < 2; p++) begin
      for (int n = 0; n < N; n++) begin
        quota[p][n] = count;
        think[p][n] = 0;
      end
    end
    wait_idle();
  endtask

  // ============================================================
  // test sequence
  // ============================================================

  initial begin
    logic [`RING_TAG_W-1:0] t;
    seed        = 32'h972f;
    clk         = 1'b0;
    rst         <= 1'b1;
    req         <= '0;
    gap_mask    = 0;
    raised      = 0;
    accepted    = 0;
    delivered   = 0;
    retired     = 0;
    outstanding = 0;
    value_errs  = 0;
    other_errs  = 0;
    seen_req    <= 1'b0;
    for (int p = 0; p < 2; p++) begin
      for (int n = 0; n < N; n++) begin
        flit[p][n]       <= '0;
        cmd[p][n]        = '0;
        has_cmd[p][n]    = 1'b0;
        quota[p][n]      = 0;
        think[p][n]      = 0;
        tag_cnt[p][n]    = '0;
        last_tag[p][n]   = '0;
        prev_ready[p][n] = 1'b1;
        wait_cnt[p][n]   = 0;
      end
    end
    for (int n = 0; n < N; n++) begin
      for (int k = 0; k < NTAG; k++) begin
        exp_req[n][k]  = '0;
        pend_dlv[n][k] = 1'b0;
        pend_ret[n][k] = 1'b0;
        rise_cyc[n][k] = 0;
        ret_cyc[n][k]  = 0;
      end
    end

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (8) tick();

    // one request at a time on an idle ring, every source and destination
    for (int s = 0; s < N; s++) begin
      for (int d = 0; d < N; d++) begin
        post_cmd((s + d) % 2, s, d, t);
        wait_idle();
      end
    end

    for (int s = 0; s < N; s++) begin
      a_before_b(s);
    end

    run_traffic(RAND_REQS, 15);
    // no think time, every port asks again as soon as it sees ready
    run_traffic(SAT_REQS, 0);

    assert (outstanding == 0 && delivered == accepted && retired == accepted) else begin
      other_errs++;
      $display("%0d accepted but %0d delivered and %0d retired", accepted, delivered, retired);
    end
    $display("value errors: %0d, other errors: %0d, requests: %0d", value_errs, other_errs,
             accepted);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: rtl/ring_bus_top.sv
// four ring nodes closed into a unidirectional ring, per-node agent ports brought out as arrays
`timescale 1ns/1ps
`include "ring_consts.svh"

module ring_bus_top (
  input  logic                   clk,
  input  logic                   rst,

  // local request ports, index is the node id
  input  logic [`RING_NODES-1:0] req_a,
  input  logic [`RING_NODES-1:0] req_b,
  input  ring_pkg::ring_req_t    req_a_flit [`RING_NODES],
  input  ring_pkg::ring_req_t    req_b_flit [`RING_NODES],
  output logic [`RING_NODES-1:0] ready_a,
  output logic [`RING_NODES-1:0] ready_b,

  // per-node delivery
  output logic [`RING_NODES-1:0] deliver_valid,
  output ring_pkg::ring_flit_t   deliver_flit [`RING_NODES],

  // per-node retire
  output logic [`RING_NODES-1:0] retire_valid,
  output logic [`RING_TAG_W-1:0] retire_tag [`RING_NODES]
);

  import ring_pkg::*;

  // ring_link[i] is the slot register of node i
  ring_flit_t ring_link [`RING_NODES];

  // ============================================================
  // nodes
  // ============================================================

  for (genvar i = 0; i < `RING_NODES; i++) begin : g_node
    // node i listens to node i-1, wrapping at zero
    ring_node #(
      .NODE_ID (`RING_ID_W'(i))
    ) node_i (
      .clk           (clk),
      .rst           (rst),
      .ring_in       (ring_link[(i + `RING_NODES - 1) % `RING_NODES]),
      .ring_out      (ring_link[i]),
      .req_a         (req_a[i]),
      .req_b         (req_b[i]),
      .req_a_flit    (req_a_flit[i]),
      .req_b_flit    (req_b_flit[i]),
      .ready_a       (ready_a[i]),
      .ready_b       (ready_b[i]),
      .deliver_valid (deliver_valid[i]),
      .deliver_flit  (deliver_flit[i]),
      .retire_valid  (retire_valid[i]),
      .retire_tag    (retire_tag[i])
    );
  end

endmodule

// File: rtl/ring_node.sv
// one stop of the slotted ring, slot register plus local inject and eject, used by ring_bus_top
`timescale 1ns/1ps
`include "ring_consts.svh"

module ring_node #(
  parameter logic [`RING_ID_W-1:0] NODE_ID = '0
) (
  input  logic                   clk,
  input  logic                   rst,

  // ring path
  input  ring_pkg::ring_flit_t   ring_in,
  output ring_pkg::ring_flit_t   ring_out,

  // local request ports
  input  logic                   req_a,
  input  logic                   req_b,
  input  ring_pkg::ring_req_t    req_a_flit,
  input  ring_pkg::ring_req_t    req_b_flit,
  output logic                   ready_a,
  output logic                   ready_b,

  // local delivery and retire
  output logic                   deliver_valid,
  output ring_pkg::ring_flit_t   deliver_flit,
  output logic                   retire_valid,
  output logic [`RING_TAG_W-1:0] retire_tag
);

  import ring_pkg::*;

  ring_req_t  held_a;
  ring_req_t  held_b;
  ring_req_t  ins_req;
  logic       full_a;
  logic       full_b;
  logic       take_a;
  logic       take_b;
  logic       remove;
  logic       free;
  ring_flit_t slot_d;
  ring_flit_t slot_q;

  // ============================================================
  // local sides
  // ============================================================

  ring_inject inject_i (
    .clk        (clk),
    .rst        (rst),
    .req_a      (req_a),
    .req_b      (req_b),
    .req_a_flit (req_a_flit),
    .req_b_flit (req_b_flit),
    .take_a     (take_a),
    .take_b     (take_b),
    .ready_a    (ready_a),
    .ready_b    (ready_b),
    .held_a     (held_a),
    .held_b     (held_b),
    .full_a     (full_a),
    .full_b     (full_b)
  );

  ring_eject #(
    .NODE_ID (NODE_ID)
  ) eject_i (
    .clk           (clk),
    .rst           (rst),
    .ring_in       (ring_in),
    .deliver_valid (deliver_valid),
    .deliver_flit  (deliver_flit),
    .retire_valid  (retire_valid),
    .retire_tag    (retire_tag),
    .remove        (remove)
  );

  // ============================================================
  // slot update
  // ============================================================

  // slot is ours to fill if empty or being retired here
  assign free    = !ring_in.used || remove;
  assign take_a  = free && full_a;
  assign take_b  = free && !full_a && full_b;
  assign ins_req = full_a ? held_a : held_b;

  always_comb begin
    slot_d = ring_in;
    if (take_a || take_b) begin
      slot_d.used = 1'b1;
      slot_d.src  = NODE_ID;
      slot_d.req  = ins_req;
    end else if (remove) begin
      slot_d.used = 1'b0;
    end
  end

  // ring never stalls, slot loads every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_q.used <= 1'b0;
    end else begin
      slot_q <= slot_d;
    end
  end

  assign ring_out = slot_q;

  // traffic from other nodes passes through untouched
  a_pass_through: assert property (
    @(posedge clk) disable iff (rst)
    (ring_in.used && !remove) |=> (ring_out == $past(ring_in))
  ) else $error("ring_node %0d overwrote a live flit", NODE_ID);

endmodule

// File: rtl/ring_eject.sv
// output side of a ring node, matches the incoming slot and pulses delivery and retire
`timescale 1ns/1ps
`include "ring_consts.svh"

module ring_eject #(
  parameter logic [`RING_ID_W-1:0] NODE_ID = '0
) (
  input  logic                   clk,
  input  logic                   rst,

  // slot arriving from the previous node
  input  ring_pkg::ring_flit_t   ring_in,

  // copy for the local agent, always accepted
  output logic                   deliver_valid,
  output ring_pkg::ring_flit_t   deliver_flit,

  // our own flit came back around
  output logic                   retire_valid,
  output logic [`RING_TAG_W-1:0] retire_tag,

  // combinational, node frees the slot on this
  output logic                   remove
);

  logic dst_hit;

  // delivery and removal are independent, self-sends hit both
  assign dst_hit = ring_in.used && (ring_in.req.dst == NODE_ID);
  assign remove  = ring_in.used && (ring_in.src == NODE_ID);

  // ============================================================
  // output pulses
  // ============================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      deliver_valid <= 1'b0;
      retire_valid  <= 1'b0;
    end else begin
      deliver_valid <= dst_hit;
      retire_valid  <= remove;
    end
  end

  // payload held until the next hit
  always_ff @(posedge clk) begin
    if (dst_hit) begin
      deliver_flit <= ring_in;
    end
    if (remove) begin
      retire_tag <= ring_in.req.tag;
    end
  end

endmodule

// File: rtl/ring_inject.sv
// input side of a ring node, one holding register per local port, instantiated by ring_node
`timescale 1ns/1ps

module ring_inject (
  input  logic                clk,
  input  logic                rst,

  // local request strobes
  input  logic                req_a,
  input  logic                req_b,
  input  ring_pkg::ring_req_t req_a_flit,
  input  ring_pkg::ring_req_t req_b_flit,

  // node has moved the held request into its slot
  input  logic                take_a,
  input  logic                take_b,

  output logic                ready_a,
  output logic                ready_b,

  // to the node's insertion mux
  output ring_pkg::ring_req_t held_a,
  output ring_pkg::ring_req_t held_b,
  output logic                full_a,
  output logic                full_b
);

  import ring_pkg::*;

  // port 0 is A, port 1 is B
  localparam int NPORT = 2;

  logic [NPORT-1:0] strobe;
  logic [NPORT-1:0] take;
  logic [NPORT-1:0] full_q;
  ring_req_t        in_req [NPORT];
  ring_req_t        held_q [NPORT];

  assign strobe    = {req_b, req_a};
  assign take      = {take_b, take_a};
  assign in_req[0] = req_a_flit;
  assign in_req[1] = req_b_flit;

  // ============================================================
  // holding registers
  // ============================================================

  // occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= '0;
    end else begin
      for (int p = 0; p < NPORT; p++) begin
        if (take[p]) begin
          full_q[p] <= 1'b0;
        end else if (strobe[p]) begin
          full_q[p] <= 1'b1;
        end
      end
    end
  end

  // payload, only loaded into an empty entry
  always_ff @(posedge clk) begin
    for (int p = 0; p < NPORT; p++) begin
      if (strobe[p] && !full_q[p]) begin
        held_q[p] <= in_req[p];
      end
    end
  end

  assign held_a  = held_q[0];
  assign held_b  = held_q[1];
  assign full_a  = full_q[0];
  assign full_b  = full_q[1];
  assign ready_a = !full_q[0];
  assign ready_b = !full_q[1];

  // ============================================================
  // checks
  // ============================================================

  for (genvar p = 0; p < NPORT; p++) begin : g_chk
    // agent must wait for ready before strobing again
    a_no_strobe_full: assert property (
      @(posedge clk) disable iff (rst) full_q[p] |-> !strobe[p]
    ) else $error("ring_inject port %0d strobed while full", p);

    // node may only take a request that is actually held
    a_take_held: assert property (
      @(posedge clk) disable iff (rst) take[p] |-> full_q[p]
    ) else $error("ring_inject port %0d taken while empty", p);
  end

endmodule

// File: rtl/ring_pkg.sv
// ring bus types shared by the RTL and the testbench, compile before any ring module
`include "ring_consts.svh"

package ring_pkg;

  // ============================================================
  // opcodes
  // ============================================================

  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_resp  = 2'd2
  } ring_op_e;

  // ============================================================
  // request and slot formats
  // ============================================================

  // what a local agent hands to its node, 24 bits
  typedef struct packed {
    logic [`RING_ID_W-1:0]   dst;
    ring_op_e                op;
    logic [`RING_ADDR_W-1:0] addr;
    logic [`RING_TAG_W-1:0]  tag;
  } ring_req_t;

  // one slot on the ring, 27 bits
  // fields other than used are don't-care on an empty slot
  typedef struct packed {
    logic                  used;
    logic [`RING_ID_W-1:0] src;
    ring_req_t             req;
  } ring_flit_t;

endpackage

// File: rtl/ring_consts.svh
// ring bus sizing constants, included by the package and by every RTL file that sizes ports
`ifndef RING_CONSTS_SVH
`define RING_CONSTS_SVH

// ============================================================
// ring geometry
// ============================================================

// stops on the ring
`define RING_NODES 4

// node id, wide enough for RING_NODES
`define RING_ID_W 2

// ============================================================
// request payload
// ============================================================

`define RING_ADDR_W 16
`define RING_TAG_W 4

`endif
